// ==== logic/fp_slice_pkg.sv ====
package fp_slice_pkg;

  // ----------------------------------------
  // Formats
  // ----------------------------------------

  // Code 3 is not a format and decodes as FP32
  typedef enum logic [1:0] {
    FMT_FP32 = 2'd0,
    FMT_FP16 = 2'd1,
    FMT_FP8  = 2'd2
  } fp_fmt_e;

  // Exponent and mantissa field widths
  localparam int unsigned FP32_EXP = 8;
  localparam int unsigned FP32_MAN = 23;
  localparam int unsigned FP16_EXP = 5;
  localparam int unsigned FP16_MAN = 10;
  localparam int unsigned FP8_EXP  = 5;
  localparam int unsigned FP8_MAN  = 2;

  // Lane count of the narrowest format in a 32-bit word
  localparam int unsigned MAX_LANES = 4;

  // ----------------------------------------
  // Operations and status
  // ----------------------------------------

  // Unlisted codes act as OP_SGNJ
  typedef enum logic [2:0] {
    OP_SGNJ  = 3'd0,
    OP_SGNJN = 3'd1,
    OP_SGNJX = 3'd2,
    OP_MIN   = 3'd3,
    OP_MAX   = 3'd4
  } op_e;

  // IEEE 754 exception flags, NV in the top bit
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // Total bit width of one value of the given format
  function automatic int unsigned fp_width(fp_fmt_e fmt);
    case (fmt)
      FMT_FP16: return 1 + FP16_EXP + FP16_MAN;
      FMT_FP8:  return 1 + FP8_EXP + FP8_MAN;
      default:  return 1 + FP32_EXP + FP32_MAN;
    endcase
  endfunction

endpackage

// ==== logic/fp_lane_op.sv ====
`timescale 1ns/10ps

module fp_lane_op
  import fp_slice_pkg::*;
#(
  parameter int unsigned ExpBits = 8,
  parameter int unsigned ManBits = 23
) (
  input  logic [ExpBits+ManBits:0] a_i,
  input  logic [ExpBits+ManBits:0] b_i,
  input  op_e                      op_i,
  output logic [ExpBits+ManBits:0] result_o,
  output logic                     nv_o
);

  localparam int unsigned LaneBits = 1 + ExpBits + ManBits;

  logic                sign_a, sign_b;
  logic [ExpBits-1:0]  exp_a, exp_b;
  logic [ManBits-1:0]  man_a, man_b;
  logic [LaneBits-2:0] mag_a, mag_b;
  logic                a_nan, b_nan;
  logic                a_snan, b_snan;
  logic                a_lt_b;
  logic                is_minmax;
  logic                sgnj_sign;
  logic [LaneBits-1:0] canon_nan;
  logic [LaneBits-1:0] minmax_res;

  // ----------------------------------------
  // Operand classification
  // ----------------------------------------
  assign {sign_a, exp_a, man_a} = a_i;
  assign {sign_b, exp_b, man_b} = b_i;
  assign mag_a = a_i[LaneBits-2:0];
  assign mag_b = b_i[LaneBits-2:0];

  assign a_nan  = (&exp_a) & (|man_a);
  assign b_nan  = (&exp_b) & (|man_b);
  // Quiet bit is the top mantissa bit
  assign a_snan = a_nan & ~man_a[ManBits-1];
  assign b_snan = b_nan & ~man_b[ManBits-1];

  // Positive zero exponent all ones, quiet bit set
  assign canon_nan = {1'b0, {ExpBits{1'b1}}, 1'b1, {(ManBits-1){1'b0}}};

  // ----------------------------------------
  // Sign injection
  // ----------------------------------------
  always_comb begin
    case (op_i)
      OP_SGNJN: sgnj_sign = ~sign_b;
      OP_SGNJX: sgnj_sign = sign_a ^ sign_b;
      default:  sgnj_sign = sign_b;
    endcase
  end

  // ----------------------------------------
  // Min / max
  // ----------------------------------------

  // Sign-magnitude order, so -0 sits below +0
  always_comb begin
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  always_comb begin
    if (a_nan && b_nan) begin
      minmax_res = canon_nan;
    end else if (a_nan) begin
      minmax_res = b_i;
    end else if (b_nan) begin
      minmax_res = a_i;
    end else if (op_i == OP_MAX) begin
      minmax_res = a_lt_b ? b_i : a_i;
    end else begin
      minmax_res = a_lt_b ? a_i : b_i;
    end
  end

  assign is_minmax = (op_i == OP_MIN) || (op_i == OP_MAX);

  assign result_o = is_minmax ? minmax_res : {sgnj_sign, mag_a};
  // Only comparisons signal invalid, and only on signaling NaNs
  assign nv_o     = is_minmax & (a_snan | b_snan);

endmodule

// ==== logic/lane_compute.sv ====
`timescale 1ns/10ps

module lane_compute
  import fp_slice_pkg::*;
#(
  parameter int unsigned Width = 32
) (
  input  logic [Width-1:0]     operand_a_i,
  input  logic [Width-1:0]     operand_b_i,
  input  op_e                  op_i,
  input  fp_fmt_e              fmt_i,
  output logic [Width-1:0]     lane_result_o,
  output logic [MAX_LANES-1:0] lane_nv_o
);

  localparam int unsigned Fp32Bits = 1 + FP32_EXP + FP32_MAN;
  localparam int unsigned Fp16Bits = 1 + FP16_EXP + FP16_MAN;
  localparam int unsigned Fp8Bits  = 1 + FP8_EXP + FP8_MAN;

  localparam int unsigned NumFp32 = Width / Fp32Bits;
  localparam int unsigned NumFp16 = Width / Fp16Bits;
  localparam int unsigned NumFp8  = Width / Fp8Bits;

  logic [Width-1:0]     res_fp32;
  logic [Width-1:0]     res_fp16;
  logic [Width-1:0]     res_fp8;
  logic [NumFp32-1:0]   nv_fp32;
  logic [NumFp16-1:0]   nv_fp16;
  logic [NumFp8-1:0]    nv_fp8;

  // ----------------------------------------
  // Lane units, all formats in parallel
  // ----------------------------------------
  for (genvar l = 0; l < NumFp32; l++) begin : gen_fp32
    fp_lane_op #(
      .ExpBits ( FP32_EXP ),
      .ManBits ( FP32_MAN )
    ) u_lane (
      .a_i      ( operand_a_i[l*Fp32Bits +: Fp32Bits] ),
      .b_i      ( operand_b_i[l*Fp32Bits +: Fp32Bits] ),
      .op_i     ( op_i                                ),
      .result_o ( res_fp32[l*Fp32Bits +: Fp32Bits]    ),
      .nv_o     ( nv_fp32[l]                          )
    );
  end

  for (genvar l = 0; l < NumFp16; l++) begin : gen_fp16
    fp_lane_op #(
      .ExpBits ( FP16_EXP ),
      .ManBits ( FP16_MAN )
    ) u_lane (
      .a_i      ( operand_a_i[l*Fp16Bits +: Fp16Bits] ),
      .b_i      ( operand_b_i[l*Fp16Bits +: Fp16Bits] ),
      .op_i     ( op_i                                ),
      .result_o ( res_fp16[l*Fp16Bits +: Fp16Bits]    ),
      .nv_o     ( nv_fp16[l]                          )
    );
  end

  for (genvar l = 0; l < NumFp8; l++) begin : gen_fp8
    fp_lane_op #(
      .ExpBits ( FP8_EXP ),
      .ManBits ( FP8_MAN )
    ) u_lane (
      .a_i      ( operand_a_i[l*Fp8Bits +: Fp8Bits] ),
      .b_i      ( operand_b_i[l*Fp8Bits +: Fp8Bits] ),
      .op_i     ( op_i                              ),
      .result_o ( res_fp8[l*Fp8Bits +: Fp8Bits]     ),
      .nv_o     ( nv_fp8[l]                         )
    );
  end

  // ----------------------------------------
  // Format select
  // ----------------------------------------

  // Lanes a format does not have come out as zero
  always_comb begin
    case (fmt_i)
      FMT_FP16: begin
        lane_result_o = res_fp16;
        lane_nv_o     = MAX_LANES'(nv_fp16);
      end
      FMT_FP8: begin
        lane_result_o = res_fp8;
        lane_nv_o     = MAX_LANES'(nv_fp8);
      end
      default: begin
        lane_result_o = res_fp32;
        lane_nv_o     = MAX_LANES'(nv_fp32);
      end
    endcase
  end

endmodule

// ==== logic/stage_pipe.sv ====
`timescale 1ns/10ps

module stage_pipe #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned DataWidth   = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [DataWidth-1:0] data_i,
  input  logic                 flush_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [DataWidth-1:0] data_o,
  output logic                 busy_o
);

  // Index i is the item after i register stages, index 0 is the input
  logic                 valid_q [0:NumPipeRegs];
  logic [DataWidth-1:0] data_q  [0:NumPipeRegs];
  logic                 ready   [0:NumPipeRegs];

  assign valid_q[0] = in_valid_i;
  assign data_q[0]  = data_i;

  // ----------------------------------------
  // Register stages
  // ----------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic load;

    // Advance when downstream takes the item or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    assign load     = ready[i] & valid_q[i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  assign ready[NumPipeRegs] = out_ready_i;
  assign in_ready_o         = ready[0];
  assign out_valid_o        = valid_q[NumPipeRegs];
  assign data_o             = data_q[NumPipeRegs];

  // Anything held in a stage counts as in flight
  always_comb begin
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NumPipeRegs; i++) begin
      busy_o = busy_o | valid_q[i];
    end
  end

endmodule

// ==== logic/result_packer.sv ====
`timescale 1ns/10ps

module result_packer
  import fp_slice_pkg::*;
#(
  parameter int unsigned Width = 32
) (
  input  logic [Width-1:0]     lane_result_i,
  input  logic [MAX_LANES-1:0] lane_nv_i,
  input  fp_fmt_e              fmt_i,
  input  logic                 vectorial_i,
  output logic [Width-1:0]     result_o,
  output status_t              status_o
);

  int unsigned          lane_bits;
  logic [MAX_LANES-1:0] active_lanes;
  logic [Width-1:0]     box_mask;

  assign lane_bits = fp_width(fmt_i);

  // ----------------------------------------
  // Lane activity
  // ----------------------------------------

  // Scalar ops use lane 0 only
  always_comb begin
    for (int unsigned i = 0; i < MAX_LANES; i++) begin
      if (vectorial_i) begin
        active_lanes[i] = (i * lane_bits) < Width;
      end else begin
        active_lanes[i] = (i == 0);
      end
    end
  end

  // ----------------------------------------
  // NaN-boxing
  // ----------------------------------------

  // Every bit above lane 0 is forced high for scalar results
  always_comb begin
    for (int unsigned b = 0; b < Width; b++) begin
      box_mask[b] = !vectorial_i && (b >= lane_bits);
    end
  end

  assign result_o = lane_result_i | box_mask;

  // ----------------------------------------
  // Status collapse
  // ----------------------------------------

  // Inactive lanes may carry garbage flags, mask them out
  always_comb begin
    status_o    = '0;
    status_o.nv = |(lane_nv_i & active_lanes);
  end

endmodule

// ==== logic/fp_noncomp_slice.sv ====
`timescale 1ns/10ps

module fp_noncomp_slice
  import fp_slice_pkg::*;
#(
  parameter int unsigned Width       = 32,
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [Width-1:0]    operand_a_i,
  input  logic [Width-1:0]    operand_b_i,
  input  op_e                 op_i,
  input  fp_fmt_e             fmt_i,
  input  logic                vectorial_i,
  input  logic [TagWidth-1:0] tag_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic                flush_i,
  output logic [Width-1:0]    result_o,
  output status_t             status_o,
  output logic [TagWidth-1:0] tag_o,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic                busy_o
);

  // Raw lanes, lane flags, vectorial, format and tag
  localparam int unsigned PayloadWidth = Width + MAX_LANES + 3 + TagWidth;

  logic [Width-1:0]        lane_result;
  logic [MAX_LANES-1:0]    lane_nv;
  logic [PayloadWidth-1:0] payload_in;
  logic [PayloadWidth-1:0] payload_out;
  logic [Width-1:0]        pipe_result;
  logic [MAX_LANES-1:0]    pipe_nv;
  logic [1:0]              pipe_fmt;
  logic                    pipe_vectorial;

  lane_compute #(
    .Width ( Width )
  ) u_lane_compute (
    .operand_a_i   ( operand_a_i ),
    .operand_b_i   ( operand_b_i ),
    .op_i          ( op_i        ),
    .fmt_i         ( fmt_i       ),
    .lane_result_o ( lane_result ),
    .lane_nv_o     ( lane_nv     )
  );

  assign payload_in = {tag_i, vectorial_i, fmt_i, lane_nv, lane_result};

  stage_pipe #(
    .NumPipeRegs ( NumPipeRegs  ),
    .DataWidth   ( PayloadWidth )
  ) u_stage_pipe (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .data_i      ( payload_in  ),
    .flush_i     ( flush_i     ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .data_o      ( payload_out ),
    .busy_o      ( busy_o      )
  );

  assign {tag_o, pipe_vectorial, pipe_fmt, pipe_nv, pipe_result} = payload_out;

  result_packer #(
    .Width ( Width )
  ) u_result_packer (
    .lane_result_i ( pipe_result            ),
    .lane_nv_i     ( pipe_nv                ),
    .fmt_i         ( fp_fmt_e'(pipe_fmt)    ),
    .vectorial_i   ( pipe_vectorial         ),
    .result_o      ( result_o               ),
    .status_o      ( status_o               )
  );

endmodule

// ==== test/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Bits per value, code 3 reads as FP32
function automatic int lane_width(input logic [1:0] fmt);
  case (fmt)
    2'd1: return 16;
    2'd2: return 8;
    default: return 32;
  endcase
endfunction

function automatic int mantissa_width(input logic [1:0] fmt);
  case (fmt)
    2'd1: return 10;
    2'd2: return 2;
    default: return 23;
  endcase
endfunction

// One lane, right aligned, with its invalid flag
function automatic logic [31:0] model_lane(input logic [2:0] op, input logic [31:0] a,
                                           input logic [31:0] b, input int w, input int mb,
                                           output logic nv);
  logic [31:0] man_mask;
  logic [31:0] mag_mask;
  logic [31:0] exp_ones;
  logic        a_nan;
  logic        b_nan;
  logic        sign;
  longint      key_a;
  longint      key_b;
  man_mask = (32'd1 << mb) - 32'd1;
  mag_mask = (32'd1 << (w - 1)) - 32'd1;
  exp_ones = mag_mask & ~man_mask;
  a_nan = ((a & exp_ones) == exp_ones) && ((a & man_mask) != 32'd0);
  b_nan = ((b & exp_ones) == exp_ones) && ((b & man_mask) != 32'd0);
  nv = (op == 3'd3 || op == 3'd4) && ((a_nan && !a[mb-1]) || (b_nan && !b[mb-1]));
  // Signed ordering key, negative values shifted down by one so -0 < +0
  key_a = longint'({32'd0, a & mag_mask});
  key_b = longint'({32'd0, b & mag_mask});
  if (a[w-1]) key_a = -key_a - 1;
  if (b[w-1]) key_b = -key_b - 1;
  case (op)
    3'd1: sign = !b[w-1];
    3'd2: sign = a[w-1] ^ b[w-1];
    3'd3, 3'd4: begin
      if (a_nan && b_nan) return exp_ones | (32'd1 << (mb - 1));
      if (a_nan) return b;
      if (b_nan) return a;
      if (op == 3'd3) return (key_a <= key_b) ? a : b;
      return (key_a >= key_b) ? a : b;
    end
    default: sign = b[w-1];
  endcase
  return (a & mag_mask) | ({31'd0, sign} << (w - 1));
endfunction

// Whole word after boxing, status with NV from active lanes only
function automatic logic [31:0] expected_word(input logic [2:0] op, input logic [1:0] fmt,
                                              input logic vec, input logic [31:0] a,
                                              input logic [31:0] b, output logic [4:0] status);
  int          w;
  logic [31:0] lane_mask;
  logic [31:0] res;
  logic [31:0] r;
  logic        nv;
  logic        lane_nv;
  w = lane_width(fmt);
  lane_mask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
  res = 32'd0;
  nv = 1'b0;
  for (int i = 0; i < 32 / w; i++) begin
    r = model_lane(op, (a >> (i * w)) & lane_mask, (b >> (i * w)) & lane_mask, w,
                   mantissa_width(fmt), lane_nv);
    res = res | (r << (i * w));
    if (vec || i == 0) nv = nv | lane_nv;
  end
  if (!vec) res = (res & lane_mask) | ~lane_mask;
  status = {nv, 4'b0000};
  return res;
endfunction

`endif

// ==== test/tb_fp_noncomp_slice.sv ====
`timescale 1ns/10ps

module tb_fp_noncomp_slice
  import fp_slice_pkg::*;
();

  localparam int NumRegs      = 2;
  localparam int NumRandItems = 300;
  // About 400 items at worst 4 cycles each, with margin
  localparam int MaxItems      = 400;
  localparam int TimeoutCycles = MaxItems * 4 * 3 + 200;

  logic        clk_i;
  logic        rst_n_i;
  logic [31:0] operand_a_i;
  logic [31:0] operand_b_i;
  op_e         op_i;
  fp_fmt_e     fmt_i;
  logic        vectorial_i;
  logic [3:0]  tag_i;
  logic        in_valid_i;
  logic        in_ready_o;
  logic        flush_i;
  logic [31:0] result_o;
  status_t     status_o;
  logic [3:0]  tag_o;
  logic        out_valid_o;
  logic        out_ready_i;
  logic        busy_o;

  integer seed;
  int     mismatches = 0;
  int     other_errors = 0;
  int     cycle_count = 0;
  int     ready_mode;
  logic   lat_check;
  logic   in_accepted = 1'b0;
  logic   flushed_q = 1'b0;
  logic   hold_q = 1'b0;
  logic [31:0] held_result;
  logic [3:0]  held_tag;

  // Scoreboard, one entry per accepted item
  logic [31:0] exp_result_q[$];
  logic [4:0]  exp_status_q[$];
  logic [3:0]  exp_tag_q[$];
  int          accept_cycle_q[$];

  `include "tb_ref_model.svh"

  fp_noncomp_slice #(
    .Width       ( 32      ),
    .NumPipeRegs ( NumRegs ),
    .TagWidth    ( 4       )
  ) dut_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .op_i        ( op_i        ),
    .fmt_i       ( fmt_i       ),
    .vectorial_i ( vectorial_i ),
    .tag_i       ( tag_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .flush_i     ( flush_i     ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .tag_o       ( tag_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  always #5 clk_i = ~clk_i;

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------

  // Next falling edge, back-pressure follows ready_mode (0 high, 1 random, 2 low)
  task automatic step();
    @(negedge clk_i);
    case (ready_mode)
      1: out_ready_i = ($unsigned($random(seed)) % 3) != 0;
      2: out_ready_i = 1'b0;
      default: out_ready_i = 1'b1;
    endcase
  endtask

  task automatic send_item(input logic [31:0] a, input logic [31:0] b, input logic [2:0] op,
                           input logic [1:0] fmt, input logic vec);
    operand_a_i = a;
    operand_b_i = b;
    op_i        = op_e'(op);
    fmt_i       = fp_fmt_e'(fmt);
    vectorial_i = vec;
    tag_i       = 4'($random(seed));
    in_valid_i  = 1'b1;
    step();
    while (!in_accepted) step();
    in_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_result_q.size() != 0) step();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, got);
    mismatches++;
  endtask

  // Random word with quiet NaN, signaling NaN and signed zero lanes mixed in
  function automatic logic [31:0] random_operand(input logic [1:0] fmt);
    int          w;
    int          mb;
    int          kind;
    logic [31:0] word;
    logic [31:0] v;
    logic [31:0] lane_mask;
    logic [31:0] exp_ones;
    w = lane_width(fmt);
    mb = mantissa_width(fmt);
    lane_mask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
    exp_ones = ((lane_mask >> 1) >> mb) << mb;
    word = $random(seed);
    for (int i = 0; i < 32 / w; i++) begin
      kind = $unsigned($random(seed)) % 16;
      case (kind)
        0: v = exp_ones | (32'd1 << (mb - 1));
        1: v = exp_ones | 32'd1;
        2: v = 32'd0;
        3: v = 32'd1 << (w - 1);
        default: v = (word >> (i * w)) & lane_mask;
      endcase
      word = (word & ~(lane_mask << (i * w))) | (v << (i * w));
    end
    return word;
  endfunction

  // ----------------------------------------
  // Monitor and checks
  // ----------------------------------------
  always @(posedge clk_i) begin : monitor
    int          n_held;
    int          acc;
    logic [31:0] res;
    logic [4:0]  st;
    logic [3:0]  tag;
    cycle_count++;
    n_held = exp_result_q.size();
    in_accepted = 1'b0;
    if (cycle_count > TimeoutCycles) begin
      other_errors++;
      $display("Timeout: run still going after %0d cycles", TimeoutCycles);
      $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
      $display("Test failed");
      $finish;
    end else if (!rst_n_i) begin
      assert (!out_valid_o && !busy_o && in_ready_o) else begin
        $display("Wrong state in reset at %0t: out_valid_o=%b busy_o=%b in_ready_o=%b",
                 $time, out_valid_o, busy_o, in_ready_o);
        other_errors++;
      end
    end else if (flush_i) begin
      exp_result_q.delete();
      exp_status_q.delete();
      exp_tag_q.delete();
      accept_cycle_q.delete();
      hold_q = 1'b0;
      flushed_q = 1'b1;
    end else begin
      if (flushed_q) begin
        assert (!busy_o && !out_valid_o) else begin
          $display("Pipeline still holds data at %0t, one cycle after a flush", $time);
          other_errors++;
        end
      end
      flushed_q = 1'b0;
      // Ready while any stage is empty or the sink takes data
      assert (in_ready_o == (n_held < NumRegs || out_ready_i)) else
        report_mismatch("in_ready_o", 32'(n_held < NumRegs || out_ready_i), 32'(in_ready_o));
      assert (busy_o == (n_held != 0)) else
        report_mismatch("busy_o", 32'(n_held != 0), 32'(busy_o));
      if (hold_q) begin
        assert (out_valid_o && result_o == held_result && tag_o == held_tag) else begin
          $display("Output changed at %0t while out_ready_i was low", $time);
          other_errors++;
        end
      end
      if (in_valid_i && in_ready_o) begin
        res = expected_word(op_i, fmt_i, vectorial_i, operand_a_i, operand_b_i, st);
        exp_result_q.push_back(res);
        exp_status_q.push_back(st);
        exp_tag_q.push_back(tag_i);
        accept_cycle_q.push_back(cycle_count);
        in_accepted = 1'b1;
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_result_q.size() == 0) begin
          $display("Output transfer at %0t with no item in flight", $time);
          other_errors++;
        end else begin
          res = exp_result_q.pop_front();
          st  = exp_status_q.pop_front();
          tag = exp_tag_q.pop_front();
          acc = accept_cycle_q.pop_front();
          assert (result_o == res) else report_mismatch("result_o", res, result_o);
          assert (status_o == st) else report_mismatch("status_o", 32'(st), 32'(status_o));
          assert (tag_o == tag) else report_mismatch("tag_o", 32'(tag), 32'(tag_o));
          if (lat_check) begin
            assert (cycle_count - acc == NumRegs) else begin
              $display("Item left after %0d cycles at %0t, expected %0d",
                       cycle_count - acc, $time, NumRegs);
              other_errors++;
            end
          end
        end
      end
      hold_q = out_valid_o && !out_ready_i;
      held_result = result_o;
      held_tag = tag_o;
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  op;
    logic [1:0]  fmt;
    seed = 98;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    operand_a_i = 32'd0;
    operand_b_i = 32'd0;
    op_i = OP_SGNJ;
    fmt_i = FMT_FP32;
    vectorial_i = 1'b0;
    tag_i = 4'd0;
    in_valid_i = 1'b0;
    flush_i = 1'b0;
    out_ready_i = 1'b1;
    ready_mode = 0;
    lat_check = 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    step();

    // Scalar sign injection in each format
    for (int f = 0; f < 3; f++) begin
      for (int o = 0; o < 3; o++) begin
        a = random_operand(2'(f));
        b = random_operand(2'(f));
        send_item(a, b, 3'(o), 2'(f), 1'b0);
      end
    end
    // Signaling NaN in the upper FP16 lane of a scalar MIN
    send_item(32'h7c01_3c00, 32'h4000_4000, 3'd3, 2'd1, 1'b0);

    // Vectorial MIN and MAX in FP16 and FP8
    for (int i = 0; i < 60; i++) begin
      op = 3'd3 + 3'(i % 2);
      fmt = 2'd1 + 2'((i / 2) % 2);
      a = random_operand(fmt);
      b = random_operand(fmt);
      send_item(a, b, op, fmt, 1'b1);
    end
    drain();
    lat_check = 1'b0;

    // Flush with one item held and a new one offered
    ready_mode = 2;
    step();
    send_item(random_operand(2'd0), random_operand(2'd0), 3'd0, 2'd0, 1'b0);
    flush_i = 1'b1;
    in_valid_i = 1'b1;
    step();
    flush_i = 1'b0;
    in_valid_i = 1'b0;
    step();
    step();

    // Random traffic against random back-pressure
    ready_mode = 1;
    for (int i = 0; i < NumRandItems; i++) begin
      fmt = 2'($unsigned($random(seed)) % 3);
      op = 3'($random(seed));
      a = random_operand(fmt);
      b = random_operand(fmt);
      send_item(a, b, op, fmt, 1'($random(seed)));
      if (($unsigned($random(seed)) % 4) == 0) step();
    end
    drain();
    ready_mode = 0;
    step();
    step();

    $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches + other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== fp_noncomp_slice.f ====
+incdir+test
logic/fp_slice_pkg.sv
logic/fp_lane_op.sv
logic/lane_compute.sv
logic/stage_pipe.sv
logic/result_packer.sv
logic/fp_noncomp_slice.sv
test/tb_fp_noncomp_slice.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the slice testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_fp_noncomp_slice \
  -f fp_noncomp_slice.f

./obj_dir/Vtb_fp_noncomp_slice | tee sim.log

if grep -q "^Test passed$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
